// File: verilog/soc_params.svh
// SoC address map and sizes
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 64

// ------------------------------
// Address map
// ------------------------------
`define ROM_BASE     32'h0000_1000
`define ROM_LENGTH   32'h0000_1000

`define SPM_BASE     32'h8000_0000
`define SPM_LENGTH   32'h0000_1000
// 512 x 64 bit fills the 4 KiB region
`define SPM_WORDS    512

`define CLINT_BASE   32'h0200_0000
`define CLINT_LENGTH 32'h0000_C000

// CLINT register offsets from CLINT_BASE
`define CLINT_MSIP_OFS     32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS    32'h0000_BFF8

// Cycles after reset before debug requests reach the core
`define DEBUG_DELAY_CYCLES 500

`endif

// File: verilog/soc_pkg.sv
// Boot SoC shared types
`include "soc_params.svh"

package soc_pkg;

  // ------------------------------
  // Bus types
  // ------------------------------
  typedef logic [`SOC_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`SOC_DATA_WIDTH-1:0]   data_t;
  typedef logic [`SOC_DATA_WIDTH/8-1:0] strb_t;

  // Targets behind the interconnect
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SPM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

  // CLINT register select
  typedef enum logic [1:0] {
    REG_MSIP,
    REG_MTIMECMP,
    REG_MTIME,
    REG_INVALID
  } clint_reg_e;

  // ------------------------------
  // Boot image
  // ------------------------------
  localparam int unsigned ROM_IMAGE_WORDS = 8;

  // Two RV64 instructions per word, low half executes first
  localparam data_t boot_image [ROM_IMAGE_WORDS] = '{
    64'h0182_b283_0000_0297,
    64'h0002_8067_f140_2573,
    64'h0000_0000_8000_0000,
    64'h0010_0073_1050_0073,
    64'h3007_3073_0080_0313,
    64'h3443_5073_0000_0013,
    64'hffdf_f06f_1050_0073,
    64'h0000_0000_0000_0013
  };

endpackage

// File: verilog/mem_interconnect.sv
// Request bus address decoder
`timescale 1ns/1ns
`include "soc_params.svh"

module mem_interconnect (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o,
  output logic           err_o,
  output logic           rom_req_o,
  output logic           spm_req_o,
  output logic           clint_req_o,
  output soc_pkg::addr_t offset_o,
  output logic           we_o,
  output soc_pkg::strb_t be_o,
  output soc_pkg::data_t wdata_o,
  input  soc_pkg::data_t rom_rdata_i,
  input  soc_pkg::data_t spm_rdata_i,
  input  soc_pkg::data_t clint_rdata_i
);

  soc_pkg::target_e tgt;
  soc_pkg::target_e tgt_q;
  soc_pkg::addr_t   base;
  logic             valid_q;
  logic             rd_q;

  // ------------------------------
  // Request side
  // ------------------------------
  always_comb begin
    tgt  = soc_pkg::TGT_NONE;
    base = '0;
    if (addr_i >= `ROM_BASE && addr_i < (`ROM_BASE + `ROM_LENGTH)) begin
      tgt  = soc_pkg::TGT_ROM;
      base = `ROM_BASE;
    end else if (addr_i >= `SPM_BASE && addr_i < (`SPM_BASE + `SPM_LENGTH)) begin
      tgt  = soc_pkg::TGT_SPM;
      base = `SPM_BASE;
    end else if (addr_i >= `CLINT_BASE && addr_i < (`CLINT_BASE + `CLINT_LENGTH)) begin
      tgt  = soc_pkg::TGT_CLINT;
      base = `CLINT_BASE;
    end
  end

  assign rom_req_o   = req_i && (tgt == soc_pkg::TGT_ROM);
  assign spm_req_o   = req_i && (tgt == soc_pkg::TGT_SPM);
  assign clint_req_o = req_i && (tgt == soc_pkg::TGT_CLINT);

  // Byte offset into the selected region
  assign offset_o = addr_i - base;
  assign we_o     = we_i;
  assign be_o     = be_i;
  assign wdata_o  = wdata_i;

  // ------------------------------
  // Response side
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      rd_q    <= 1'b0;
      tgt_q   <= soc_pkg::TGT_NONE;
    end else begin
      valid_q <= req_i;
      rd_q    <= req_i && !we_i;
      tgt_q   <= tgt;
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = valid_q && (tgt_q == soc_pkg::TGT_NONE);

  // Writes and unmapped hits return zero
  always_comb begin
    rdata_o = '0;
    if (rd_q) begin
      case (tgt_q)
        soc_pkg::TGT_ROM:   rdata_o = rom_rdata_i;
        soc_pkg::TGT_SPM:   rdata_o = spm_rdata_i;
        soc_pkg::TGT_CLINT: rdata_o = clint_rdata_i;
        default:            rdata_o = '0;
      endcase
    end
  end

  // An unknown address or direction would pick a random target
  a_req_known: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i |-> !$isunknown({we_i, addr_i}));

endmodule

// File: verilog/boot_rom.sv
// Boot ROM
`timescale 1ns/1ns
`include "soc_params.svh"

module boot_rom (
  input  logic           clk_i,
  input  logic           req_i,
  input  soc_pkg::addr_t offset_i,
  output soc_pkg::data_t rdata_o
);

  logic [`SOC_ADDR_WIDTH-4:0] word_idx;

  assign word_idx = offset_i[`SOC_ADDR_WIDTH-1:3];

  // Rest of the 4 KiB region past the image reads as zero
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (word_idx < soc_pkg::ROM_IMAGE_WORDS) begin
        rdata_o <= soc_pkg::boot_image[word_idx[2:0]];
      end else begin
        rdata_o <= '0;
      end
    end
  end

endmodule

// File: verilog/scratchpad_ram.sv
// Scratchpad RAM
`timescale 1ns/1ns
`include "soc_params.svh"

module scratchpad_ram (
  input  logic           clk_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t offset_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output soc_pkg::data_t rdata_o
);

  localparam int unsigned idx_w    = $clog2(`SPM_WORDS);
  localparam int unsigned num_strb = $bits(soc_pkg::strb_t);

  soc_pkg::data_t   mem_q [`SPM_WORDS];
  logic [idx_w-1:0] word_idx;

  assign word_idx = offset_i[idx_w+2:3];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < num_strb; b++) begin
          if (be_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_o <= '0;
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

  a_offset_known: assert property (@(posedge clk_i) req_i |-> !$isunknown(offset_i));

endmodule

// File: verilog/clint_timer.sv
// Core-local interruptor
`timescale 1ns/1ns
`include "soc_params.svh"

module clint_timer (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t offset_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output soc_pkg::data_t rdata_o,
  input  logic           rtc_i,
  output logic           timer_irq_o,
  output logic           ipi_o
);

  soc_pkg::clint_reg_e reg_sel;
  soc_pkg::addr_t      word_ofs;
  soc_pkg::data_t      be_mask;
  soc_pkg::data_t      mtimecmp_q;
  soc_pkg::data_t      mtime_q;
  logic                msip_q;
  logic                rtc_phase_q;
  logic                mtime_tick;
  logic                wr_en;

  // ------------------------------
  // Register decode
  // ------------------------------
  assign word_ofs = {offset_i[`SOC_ADDR_WIDTH-1:3], 3'b000};

  always_comb begin
    case (word_ofs)
      `CLINT_MSIP_OFS:     reg_sel = soc_pkg::REG_MSIP;
      `CLINT_MTIMECMP_OFS: reg_sel = soc_pkg::REG_MTIMECMP;
      `CLINT_MTIME_OFS:    reg_sel = soc_pkg::REG_MTIME;
      default:             reg_sel = soc_pkg::REG_INVALID;
    endcase
  end

  always_comb begin
    for (int b = 0; b < $bits(soc_pkg::strb_t); b++) begin
      be_mask[8*b +: 8] = {8{be_i[b]}};
    end
  end

  assign wr_en = req_i && we_i;

  // mtime runs at half the RTC strobe rate
  assign mtime_tick = rtc_i && rtc_phase_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q      <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
      rtc_phase_q <= 1'b0;
    end else begin
      if (rtc_i) begin
        rtc_phase_q <= ~rtc_phase_q;
      end
      if (wr_en && reg_sel == soc_pkg::REG_MSIP && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (wr_en && reg_sel == soc_pkg::REG_MTIMECMP) begin
        mtimecmp_q <= (mtimecmp_q & ~be_mask) | (wdata_i & be_mask);
      end
      // Software write beats the tick
      if (wr_en && reg_sel == soc_pkg::REG_MTIME) begin
        mtime_q <= (mtime_q & ~be_mask) | (wdata_i & be_mask);
      end else if (mtime_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= '0;
      if (!we_i) begin
        case (reg_sel)
          soc_pkg::REG_MSIP:     rdata_o <= {{($bits(soc_pkg::data_t)-1){1'b0}}, msip_q};
          soc_pkg::REG_MTIMECMP: rdata_o <= mtimecmp_q;
          soc_pkg::REG_MTIME:    rdata_o <= mtime_q;
          default:               rdata_o <= '0;
        endcase
      end
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

// File: verilog/debug_req_gate.sv
// Debug request gate
`timescale 1ns/1ns
`include "soc_params.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned cnt_w = $clog2(`DEBUG_DELAY_CYCLES + 1);

  logic [cnt_w-1:0] cnt_q;

  // Gives the boot code time to run before a halt can land
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= cnt_w'(`DEBUG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

  // An unknown request would reach the core once the gate opens
  a_req_known: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !$isunknown(debug_req_i));

endmodule

// File: verilog/boot_soc_top.sv
// Boot SoC memory subsystem top
`timescale 1ns/1ns

module boot_soc_top (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o,
  output logic           err_o,
  input  logic           rtc_i,
  input  logic           debug_req_i,
  output logic           timer_irq_o,
  output logic           ipi_o,
  output logic           debug_req_o
);

  logic           rom_req;
  logic           spm_req;
  logic           clint_req;
  soc_pkg::addr_t offset;
  logic           we;
  soc_pkg::strb_t be;
  soc_pkg::data_t wdata;
  soc_pkg::data_t rom_rdata;
  soc_pkg::data_t spm_rdata;
  soc_pkg::data_t clint_rdata;

  mem_interconnect i_interconnect (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .be_i          ( be_i        ),
    .wdata_i       ( wdata_i     ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     ),
    .err_o         ( err_o       ),
    .rom_req_o     ( rom_req     ),
    .spm_req_o     ( spm_req     ),
    .clint_req_o   ( clint_req   ),
    .offset_o      ( offset      ),
    .we_o          ( we          ),
    .be_o          ( be          ),
    .wdata_o       ( wdata       ),
    .rom_rdata_i   ( rom_rdata   ),
    .spm_rdata_i   ( spm_rdata   ),
    .clint_rdata_i ( clint_rdata )
  );

  boot_rom i_bootrom (
    .clk_i    ( clk_i     ),
    .req_i    ( rom_req   ),
    .offset_i ( offset    ),
    .rdata_o  ( rom_rdata )
  );

  scratchpad_ram i_spm (
    .clk_i    ( clk_i     ),
    .req_i    ( spm_req   ),
    .we_i     ( we        ),
    .offset_i ( offset    ),
    .be_i     ( be        ),
    .wdata_i  ( wdata     ),
    .rdata_o  ( spm_rdata )
  );

  // CLINT gets the raw RTC strobe and halves it internally
  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( clint_req   ),
    .we_i        ( we          ),
    .offset_i    ( offset      ),
    .be_i        ( be          ),
    .wdata_i     ( wdata       ),
    .rdata_o     ( clint_rdata ),
    .rtc_i       ( rtc_i       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: verification/boot_soc_tb.sv
// Boot SoC testbench
`timescale 1ns/1ns
`include "soc_params.svh"

module boot_soc_tb;

  localparam int unsigned timeout_cycles = 50;

  typedef enum logic {OP_READ, OP_WRITE} op_e;

  typedef struct packed {
    op_e            op;
    soc_pkg::addr_t addr;
    soc_pkg::strb_t be;
    soc_pkg::data_t wdata;
    soc_pkg::data_t exp_rdata;
    logic           exp_err;
    logic           chain;
  } entry_t;

  logic           clk_i;
  logic           ndmreset_n;
  logic           req_i;
  logic           we_i;
  soc_pkg::addr_t addr_i;
  soc_pkg::strb_t be_i;
  soc_pkg::data_t wdata_i;
  logic           rvalid_o;
  soc_pkg::data_t rdata_o;
  logic           err_o;
  logic           rtc_i;
  logic           debug_req_i;
  logic           timer_irq_o;
  logic           ipi_o;
  logic           debug_req_o;

  entry_t         table_q [$];
  int             next_idx;
  integer         seed;
  int             rtc_strobes;
  // Reference copy of the scratchpad
  soc_pkg::data_t spm_ref [`SPM_WORDS];

  boot_soc_top dut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .rvalid_o    ( rvalid_o    ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .rtc_i       ( rtc_i       ),
    .debug_req_i ( debug_req_i ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  always #10 clk_i = ~clk_i;

  // ------------------------------
  // Reporting and compares
  // ------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_rdata(input string name, input soc_pkg::data_t got,
                             input soc_pkg::data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ------------------------------
  // Table building
  // ------------------------------
  function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_w,
                                                 input soc_pkg::data_t new_w,
                                                 input soc_pkg::strb_t be);
    soc_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic soc_pkg::data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic void add_entry(input op_e op, input soc_pkg::addr_t addr,
                                    input soc_pkg::strb_t be, input soc_pkg::data_t wdata,
                                    input soc_pkg::data_t exp_rdata, input logic exp_err,
                                    input logic chain);
    entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.be        = be;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    e.chain     = chain;
    table_q.push_back(e);
  endfunction

  function automatic void spm_write(input int word, input soc_pkg::strb_t be,
                                    input soc_pkg::data_t wdata, input logic chain);
    spm_ref[word] = merge_bytes(spm_ref[word], wdata, be);
    add_entry(OP_WRITE, soc_pkg::addr_t'(`SPM_BASE + word * 8), be, wdata, '0, 1'b0, chain);
  endfunction

  function automatic void spm_read(input int word, input logic chain);
    add_entry(OP_READ, soc_pkg::addr_t'(`SPM_BASE + word * 8), '0, '0, spm_ref[word], 1'b0,
              chain);
  endfunction

  // ------------------------------
  // Bus driving
  // ------------------------------
  task automatic wait_rvalid(input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!rvalid_o && cycles < timeout_cycles) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!rvalid_o) report_failure($sformatf("no response to table entry %0d", idx));
  endtask

  task automatic check_entry(input int idx);
    check_rdata($sformatf("rdata_o entry %0d", idx), rdata_o, table_q[idx].exp_rdata);
    check_flag($sformatf("err_o entry %0d", idx), err_o, table_q[idx].exp_err);
  endtask

  // Chained entries go out on consecutive cycles
  task automatic apply_burst(input int first, input int count);
    fork
      begin
        for (int k = 0; k < count; k++) begin
          @(posedge clk_i);
          req_i   <= 1'b1;
          we_i    <= (table_q[first + k].op == OP_WRITE);
          addr_i  <= table_q[first + k].addr;
          be_i    <= table_q[first + k].be;
          wdata_i <= table_q[first + k].wdata;
        end
        @(posedge clk_i);
        req_i <= 1'b0;
        we_i  <= 1'b0;
      end
      begin
        wait_rvalid(first);
        check_entry(first);
        for (int k = 1; k < count; k++) begin
          @(negedge clk_i);
          if (!rvalid_o) report_failure($sformatf("response %0d not back to back", first + k));
          check_entry(first + k);
        end
      end
    join
  endtask

  task automatic run_pending();
    int last;
    while (next_idx < table_q.size()) begin
      last = next_idx;
      while (table_q[last].chain && last + 1 < table_q.size()) last++;
      apply_burst(next_idx, last - next_idx + 1);
      next_idx = last + 1;
    end
  endtask

  task automatic rtc_pulses(input int n);
    repeat (n) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      @(posedge clk_i);
      rtc_i <= 1'b0;
      rtc_strobes++;
    end
  endtask

  // ------------------------------
  // Sequence
  // ------------------------------
  initial begin
    int edges;
    clk_i       = 1'b0;
    ndmreset_n  = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    be_i        = '0;
    wdata_i     = '0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    seed        = 32'hdc250fcc;
    rtc_strobes = 0;
    next_idx    = 0;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("rvalid_o", rvalid_o, 1'b0);
    check_flag("err_o", err_o, 1'b0);
    check_flag("timer_irq_o", timer_irq_o, 1'b0);
    check_flag("ipi_o", ipi_o, 1'b0);
    check_flag("debug_req_o", debug_req_o, 1'b0);
    @(posedge clk_i);
    ndmreset_n <= 1'b1;

    // Debug gate opens on the last edge of the window
    edges = 0;
    while (edges <= `DEBUG_DELAY_CYCLES) begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
      check_flag("debug_req_o", debug_req_o, edges >= `DEBUG_DELAY_CYCLES);
    end
    @(posedge clk_i);
    debug_req_i <= 1'b0;
    @(negedge clk_i);
    check_flag("debug_req_o", debug_req_o, 1'b0);

    // ROM image, then one word past it
    for (int k = 0; k < soc_pkg::ROM_IMAGE_WORDS; k++) begin
      add_entry(OP_READ, soc_pkg::addr_t'(`ROM_BASE + 8 * k), '0, '0, soc_pkg::boot_image[k],
                1'b0, k < soc_pkg::ROM_IMAGE_WORDS - 1);
    end
    add_entry(OP_READ, `ROM_BASE + 32'h40, '0, '0, '0, 1'b0, 1'b0);
    run_pending();

    // Scratchpad full writes, partial writes, read back
    for (int w = 0; w < 6; w++) spm_write(w, 8'hff, rand_word(), 1'b1);
    spm_write(0, 8'h0f, rand_word(), 1'b1);
    spm_write(1, 8'ha5, rand_word(), 1'b1);
    spm_write(2, 8'h3c, rand_word(), 1'b1);
    spm_write(3, 8'h81, rand_word(), 1'b0);
    for (int w = 0; w < 6; w++) spm_read(w, w < 5);
    run_pending();

    // Just past the scratchpad would alias word 0 if decoded wrongly
    add_entry(OP_WRITE, `SPM_BASE + `SPM_LENGTH, 8'hff, rand_word(), '0, 1'b1, 1'b0);
    add_entry(OP_READ, 32'h4000_0000, '0, '0, '0, 1'b1, 1'b0);
    spm_read(0, 1'b0);
    run_pending();

    // ------------------------------
    // CLINT
    // ------------------------------
    add_entry(OP_WRITE, `CLINT_BASE + `CLINT_MSIP_OFS, 8'h01, 64'h1, '0, 1'b0, 1'b0);
    run_pending();
    check_flag("ipi_o", ipi_o, 1'b1);
    add_entry(OP_WRITE, `CLINT_BASE + `CLINT_MSIP_OFS, 8'h01, 64'h0, '0, 1'b0, 1'b0);
    run_pending();
    check_flag("ipi_o", ipi_o, 1'b0);

    rtc_pulses(6);
    add_entry(OP_READ, `CLINT_BASE + `CLINT_MTIME_OFS, '0, '0,
              soc_pkg::data_t'(rtc_strobes / 2), 1'b0, 1'b0);
    add_entry(OP_WRITE, `CLINT_BASE + `CLINT_MTIMECMP_OFS, 8'hff,
              soc_pkg::data_t'(rtc_strobes / 2 + 1), '0, 1'b0, 1'b0);
    add_entry(OP_READ, `CLINT_BASE + `CLINT_MTIMECMP_OFS, '0, '0,
              soc_pkg::data_t'(rtc_strobes / 2 + 1), 1'b0, 1'b0);
    run_pending();
    check_flag("timer_irq_o", timer_irq_o, 1'b0);
    // One strobe only flips the RTC phase
    rtc_pulses(1);
    @(negedge clk_i);
    check_flag("timer_irq_o", timer_irq_o, 1'b0);
    rtc_pulses(1);
    @(negedge clk_i);
    check_flag("timer_irq_o", timer_irq_o, 1'b1);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: boot_soc.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/mem_interconnect.sv
verilog/boot_rom.sv
verilog/scratchpad_ram.sv
verilog/clint_timer.sv
verilog/debug_req_gate.sv
verilog/boot_soc_top.sv
verification/boot_soc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = boot_soc_tb
FILELIST  = boot_soc.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
